//--- common/ex_pkg.sv
`default_nettype none

package ex_pkg;

	// ----------------------------------------
	// operation and size codes
	// ----------------------------------------

	// the shifter only looks at bit 0: 0 is left, 1 is right
	typedef enum logic [2:0] {
		aluk_add    = 3'd0,
		aluk_sub    = 3'd1,
		aluk_and    = 3'd2,
		aluk_or     = 3'd3,
		aluk_xor    = 3'd4,
		aluk_pass_b = 3'd5,
		aluk_shl    = 3'd6,
		aluk_shr    = 3'd7
	} aluk_t;

	// operand size in bytes
	typedef enum logic [1:0] {
		size_1 = 2'd0,
		size_2 = 2'd1,
		size_4 = 2'd2,
		size_8 = 2'd3
	} datasize_t;

	typedef logic [31:0] word_t;

	// ----------------------------------------
	// flag bit positions
	// ----------------------------------------
	localparam int flag_cf = 0;
	localparam int flag_pf = 2;
	localparam int flag_af = 4;
	localparam int flag_zf = 6;
	localparam int flag_sf = 7;
	localparam int flag_df = 10;
	localparam int flag_of = 11;

	// pop increment and string-pointer step, indexed by datasize
	localparam word_t step_bytes [4] = '{32'd1, 32'd2, 32'd4, 32'd8};

	// ----------------------------------------
	// writeback latch payloads
	// ----------------------------------------
	typedef struct packed {
		word_t result_a;
		word_t result_b;
		word_t result_c;
		word_t flags;
	} wb_data_t;

	typedef struct packed {
		logic v;
		logic ld_gpr1;
		logic ld_gpr2;
		logic ld_gpr3;
		logic dcache_write;
	} wb_ctrl_t;

endpackage

`default_nettype wire

//--- dv/ex_checker.sv
`timescale 1ns/10ps
`default_nettype none

module ex_checker import ex_pkg::*; (
	input logic  CLK,
	input logic  rst_n,
	input logic  wb_stall,
	input logic  is_cmpxchg,
	input logic  wb_v,
	input logic  wb_ld_gpr1,
	input logic  wb_ld_gpr2,
	input logic  wb_ld_gpr3,
	input logic  wb_dcache_write,
	input word_t wb_result_a,
	input word_t wb_result_b,
	input word_t wb_result_c,
	input word_t wb_flags
);

	logic any_write;

	assign any_write = wb_ld_gpr1 | wb_ld_gpr2 | wb_ld_gpr3 | wb_dcache_write;

	// ----------------------------------------
	// writeback latch properties
	// ----------------------------------------
	a_reset_clears_v: assert property (@(posedge CLK) !rst_n |=> !wb_v)
		else $error("wb_v set in the cycle after reset");

	a_write_needs_v: assert property (@(posedge CLK) disable iff (!rst_n) any_write |-> wb_v)
		else $error("write enable out while wb_v is low");

	// only loaded cmpxchg cycles count since a stall shows the older latch contents
	a_cmpxchg_one_gpr: assert property (@(posedge CLK) disable iff (!rst_n)
		(is_cmpxchg && !wb_stall) |=> !(wb_ld_gpr1 && wb_ld_gpr2))
		else $error("cmpxchg enabled gpr1 and gpr2 together");

	a_stall_holds: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_stall |=> $stable(wb_v)
		&& $stable({wb_ld_gpr1, wb_ld_gpr2, wb_ld_gpr3, wb_dcache_write})
		&& $stable(wb_result_a) && $stable(wb_result_b) && $stable(wb_result_c)
		&& $stable(wb_flags))
		else $error("writeback outputs moved during a stall");

endmodule

bind ex_stage_top ex_checker i_checker (
	.CLK             (CLK),
	.rst_n           (rst_n),
	.wb_stall        (wb_stall),
	.is_cmpxchg      (is_cmpxchg),
	.wb_v            (wb_v),
	.wb_ld_gpr1      (wb_ld_gpr1),
	.wb_ld_gpr2      (wb_ld_gpr2),
	.wb_ld_gpr3      (wb_ld_gpr3),
	.wb_dcache_write (wb_dcache_write),
	.wb_result_a     (wb_result_a),
	.wb_result_b     (wb_result_b),
	.wb_result_c     (wb_result_c),
	.wb_flags        (wb_flags)
);

`default_nettype wire

//--- dv/ex_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ex_tb import ex_pkg::*; ();

	localparam int reset_timeout = 20;
	localparam int stall_timeout = 20;

	// one table row of stimulus
	typedef struct packed {
		logic       ex_v;
		word_t      ex_a;
		word_t      ex_b;
		word_t      ex_c;
		aluk_t      aluk;
		datasize_t  datasize;
		logic       is_alu32;
		logic       is_alu32_flags;
		logic       is_cmps_first;
		logic       is_cmps_second;
		logic       is_xchg;
		logic       is_cmpxchg;
		logic       pass_a;
		logic       alu_to_b;
		logic       mux_sp_pop;
		logic       mux_cmps_pointer;
		logic       repne_steady;
		logic       repne;
		logic       ld_gpr1;
		logic       ld_gpr2;
		logic       ld_gpr3;
		logic       dcache_write;
		word_t      saved_count;
		word_t      flags_fwd;
		logic       repne_terminate;
		logic [3:0] stall_cycles;
	} stim_t;

	// expected writeback outputs for that row
	typedef struct packed {
		logic  v;
		logic  ld_gpr1;
		logic  ld_gpr2;
		logic  ld_gpr3;
		logic  dcache_write;
		word_t result_a;
		word_t result_b;
		word_t result_c;
		word_t flags;
	} expect_t;

	logic      CLK;
	logic      rst_n;
	logic      ex_v;
	word_t     ex_a;
	word_t     ex_b;
	word_t     ex_c;
	aluk_t     aluk;
	datasize_t datasize;
	logic      is_alu32;
	logic      is_alu32_flags;
	logic      is_cmps_first;
	logic      is_cmps_second;
	logic      is_xchg;
	logic      is_cmpxchg;
	logic      pass_a;
	logic      alu_to_b;
	logic      mux_sp_pop;
	logic      mux_cmps_pointer;
	logic      repne_steady;
	logic      repne;
	logic      ld_gpr1;
	logic      ld_gpr2;
	logic      ld_gpr3;
	logic      dcache_write;
	word_t     saved_count;
	word_t     flags_fwd;
	logic      wb_stall;
	logic      repne_terminate;
	logic      wb_v;
	logic      wb_ld_gpr1;
	logic      wb_ld_gpr2;
	logic      wb_ld_gpr3;
	logic      wb_dcache_write;
	word_t     wb_result_a;
	word_t     wb_result_b;
	word_t     wb_result_c;
	word_t     wb_flags;

	stim_t   stim_q[$];
	expect_t expect_q[$];
	string   name_q[$];
	stim_t   cur;
	word_t   model_saved;
	word_t   lfsr_state;
	int      checks;
	int      errors;
	logic    timed_out;

	ex_tb_clock u_clock (
		.CLK   (CLK),
		.rst_n (rst_n)
	);

	ex_stage_top i_dut (.*);

	// ----------------------------------------
	// fibonacci lfsr with taps 32 22 2 1
	// ----------------------------------------
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic word_t random_bits(int nbits);
		word_t value;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			value = {value[30:0], lfsr_step()};
		end
		return value;
	endfunction

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic void model_alu(input aluk_t op, input datasize_t size, input word_t a,
		input word_t b, input logic cf_in, input logic af_in, output word_t res,
		output word_t fl);
		int          n;
		word_t       mask;
		logic [63:0] am;
		logic [63:0] bm;
		logic [63:0] wide;
		logic        c;
		logic        h;
		logic        o;
		n = (size == size_1) ? 8 : ((size == size_2) ? 16 : 32);
		mask = (n == 32) ? 32'hffff_ffff : ((32'd1 << n) - 32'd1);
		am = {32'd0, a & mask};
		bm = {32'd0, b & mask};
		c = cf_in;
		h = af_in;
		o = 1'b0;
		case (op)
			aluk_add: begin
				wide = am + bm;
				c = wide[n];
				h = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
				o = (am[n - 1] == bm[n - 1]) && (wide[n - 1] != am[n - 1]);
			end
			aluk_sub: begin
				wide = am - bm;
				c = am < bm;
				h = a[3:0] < b[3:0];
				o = (am[n - 1] != bm[n - 1]) && (wide[n - 1] != am[n - 1]);
			end
			aluk_and: wide = am & bm;
			aluk_or:  wide = am | bm;
			aluk_xor: wide = am ^ bm;
			default:  wide = bm;
		endcase
		res = wide[31:0] & mask;
		fl = '0;
		fl[flag_cf] = c;
		fl[flag_pf] = ~^res[7:0];
		fl[flag_af] = h;
		fl[flag_zf] = (res == 32'd0);
		fl[flag_sf] = res[n - 1];
		fl[flag_of] = o;
	endfunction

	// bit 0 of the code picks right and the count is ex_b[4:0]
	function automatic void model_shift(input aluk_t op, input word_t a, input word_t b,
		input word_t fwd, output word_t res, output word_t fl);
		int n;
		n = int'(b[4:0]);
		fl = fwd;
		if (op[0]) begin
			res = a >> n;
			if (n != 0) begin
				fl[flag_cf] = a[n - 1];
			end
		end else begin
			res = a << n;
			if (n != 0) begin
				fl[flag_cf] = a[32 - n];
			end
		end
	endfunction

	task automatic add_row(input string name);
		expect_t e;
		word_t   b;
		word_t   count;
		word_t   alu_res;
		word_t   alu_fl;
		word_t   sh_res;
		word_t   sh_fl;
		word_t   step;
		word_t   pointer;
		logic    zf;
		b = cur.is_cmps_second ? model_saved : cur.ex_b;
		count = cur.repne_steady ? cur.saved_count : cur.ex_c;
		model_alu(cur.aluk, cur.datasize, cur.ex_a, b, cur.flags_fwd[flag_cf],
			cur.flags_fwd[flag_af], alu_res, alu_fl);
		model_shift(cur.aluk, cur.ex_a, cur.ex_b, cur.flags_fwd, sh_res, sh_fl);
		step = 32'd1 << cur.datasize;
		pointer = cur.flags_fwd[flag_df] ? cur.ex_b - step : cur.ex_b + step;
		zf = alu_fl[flag_zf];

		e.v = cur.ex_v & (~cur.repne | cur.repne_terminate);
		e.ld_gpr1 = cur.ex_v & cur.ld_gpr1 & (~cur.is_cmpxchg | zf);
		e.ld_gpr2 = cur.ex_v & cur.ld_gpr2 & (~cur.is_cmpxchg | ~zf);
		e.ld_gpr3 = cur.ex_v & cur.ld_gpr3;
		e.dcache_write = cur.ex_v & cur.dcache_write & (~cur.is_cmpxchg | zf);

		if (cur.is_alu32) begin
			e.result_a = alu_res;
		end else if (cur.mux_cmps_pointer) begin
			e.result_a = pointer;
		end else if (cur.is_cmps_first || cur.is_xchg) begin
			e.result_a = cur.ex_b;
		end else if (cur.pass_a) begin
			e.result_a = cur.ex_a;
		end else if (cur.is_cmpxchg) begin
			e.result_a = cur.ex_c;
		end else begin
			e.result_a = sh_res;
		end

		if (cur.mux_cmps_pointer) begin
			e.result_b = pointer;
		end else if (cur.alu_to_b) begin
			e.result_b = alu_res;
		end else if (cur.is_cmpxchg || cur.is_xchg) begin
			e.result_b = cur.ex_a;
		end else begin
			e.result_b = cur.ex_b;
		end

		if (cur.is_cmps_first || cur.is_cmps_second) begin
			e.result_c = count - 32'd1;
		end else if (cur.mux_sp_pop) begin
			e.result_c = cur.ex_c + step;
		end else begin
			e.result_c = cur.ex_c;
		end
		e.flags = cur.is_alu32_flags ? alu_fl : sh_fl;

		stim_q.push_back(cur);
		expect_q.push_back(e);
		name_q.push_back(name);
		// the DUT captures on the edge that loads this row
		if (cur.is_cmps_first) begin
			model_saved = cur.ex_a;
		end
	endtask

	task automatic clear_row();
		cur = '0;
		cur.ex_v = 1'b1;
		cur.aluk = aluk_add;
		cur.datasize = size_4;
	endtask

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------
	task automatic build_table();
		word_t first_a;
		for (int s = 0; s < 3; s++) begin
			for (int k = 0; k < 5; k++) begin
				clear_row();
				cur.aluk = aluk_t'(k[2:0]);
				cur.datasize = datasize_t'(s[1:0]);
				cur.ex_a = random_bits(32);
				cur.ex_b = random_bits(32);
				cur.flags_fwd = random_bits(32);
				cur.is_alu32 = 1'b1;
				cur.is_alu32_flags = 1'b1;
				cur.ld_gpr1 = 1'b1;
				add_row($sformatf("alu op%0d size%0d", k, s));
			end
		end
		// signed overflow at byte size, borrow and equal compare
		clear_row();
		cur.datasize = size_1;
		cur.ex_a = 32'h1234_567f;
		cur.ex_b = 32'h0000_0001;
		cur.is_alu32 = 1'b1;
		cur.is_alu32_flags = 1'b1;
		add_row("add overflow");
		clear_row();
		cur.aluk = aluk_sub;
		cur.ex_a = 32'd5;
		cur.ex_b = 32'd7;
		cur.is_alu32 = 1'b1;
		cur.is_alu32_flags = 1'b1;
		add_row("sub borrow");
		clear_row();
		cur.aluk = aluk_sub;
		cur.datasize = size_2;
		cur.ex_a = 32'h1234_abcd;
		cur.ex_b = 32'h9999_abcd;
		cur.is_alu32 = 1'b1;
		cur.is_alu32_flags = 1'b1;
		add_row("cmp equal word");

		// shifts ignore the upper bits of ex_b
		for (int k = 0; k < 4; k++) begin
			clear_row();
			cur.aluk = k[0] ? aluk_shr : aluk_shl;
			cur.ex_a = random_bits(32);
			cur.ex_b = (random_bits(32) & ~32'h1f) | (random_bits(4) + 32'd1 + 32'(k[1]) * 32'd15);
			cur.flags_fwd = random_bits(32);
			cur.ld_gpr1 = 1'b1;
			add_row($sformatf("shift %0d", k));
		end
		// forwarded carry set so that a zero count must keep it
		for (int k = 0; k < 2; k++) begin
			clear_row();
			cur.aluk = k[0] ? aluk_shr : aluk_shl;
			cur.ex_a = random_bits(32);
			cur.ex_b = random_bits(32) & ~32'h1f;
			cur.flags_fwd = random_bits(32) | (32'd1 << flag_cf);
			add_row($sformatf("shift zero %0d", k));
		end

		// cmpxchg equal then unequal
		for (int k = 0; k < 2; k++) begin
			clear_row();
			cur.aluk = aluk_sub;
			cur.is_cmpxchg = 1'b1;
			cur.is_alu32_flags = 1'b1;
			cur.ld_gpr1 = 1'b1;
			cur.ld_gpr2 = 1'b1;
			cur.dcache_write = 1'b1;
			cur.ex_a = random_bits(32);
			cur.ex_b = cur.ex_a ^ (k[0] ? 32'h0000_0100 : 32'h0);
			cur.ex_c = random_bits(32);
			add_row(k[0] ? "cmpxchg unequal" : "cmpxchg equal");
		end

		// string compare pairs with the pointer up then down
		for (int k = 0; k < 2; k++) begin
			clear_row();
			cur.is_cmps_first = 1'b1;
			cur.mux_cmps_pointer = 1'b1;
			cur.ld_gpr3 = 1'b1;
			cur.datasize = k[0] ? size_4 : size_2;
			cur.ex_a = random_bits(32);
			cur.ex_b = random_bits(32);
			cur.ex_c = random_bits(32);
			cur.flags_fwd = random_bits(32) & ~(32'd1 << flag_df);
			cur.flags_fwd = cur.flags_fwd | (32'(k[0]) << flag_df);
			first_a = cur.ex_a;
			add_row(k[0] ? "cmps first down" : "cmps first up");
			clear_row();
			cur.is_cmps_second = 1'b1;
			cur.aluk = aluk_sub;
			cur.alu_to_b = 1'b1;
			cur.is_alu32_flags = 1'b1;
			cur.ld_gpr3 = 1'b1;
			cur.datasize = k[0] ? size_4 : size_2;
			cur.ex_a = k[0] ? first_a : random_bits(32);
			cur.ex_b = random_bits(32);
			cur.ex_c = random_bits(32);
			cur.repne = k[0];
			cur.repne_steady = k[0];
			cur.repne_terminate = k[0];
			cur.saved_count = random_bits(32);
			add_row(k[0] ? "cmps second repne" : "cmps second");
		end

		// pop and xchg routing
		for (int k = 0; k < 2; k++) begin
			clear_row();
			cur.mux_sp_pop = 1'b1;
			cur.pass_a = 1'b1;
			cur.datasize = k[0] ? size_8 : size_4;
			cur.ex_a = random_bits(32);
			cur.ex_c = random_bits(32);
			cur.ld_gpr1 = 1'b1;
			cur.ld_gpr3 = 1'b1;
			add_row(k[0] ? "pop 8" : "pop 4");
		end
		clear_row();
		cur.is_xchg = 1'b1;
		cur.ex_a = random_bits(32);
		cur.ex_b = random_bits(32);
		cur.ld_gpr1 = 1'b1;
		cur.ld_gpr2 = 1'b1;
		add_row("xchg");

		// bubbles and stalls
		clear_row();
		cur.ex_v = 1'b0;
		cur.is_alu32 = 1'b1;
		cur.ex_a = random_bits(32);
		cur.ex_b = random_bits(32);
		cur.ld_gpr1 = 1'b1;
		cur.ld_gpr2 = 1'b1;
		cur.ld_gpr3 = 1'b1;
		cur.dcache_write = 1'b1;
		add_row("bubble");
		clear_row();
		cur.repne = 1'b1;
		cur.ex_a = random_bits(32);
		add_row("repne running");
		clear_row();
		cur.repne = 1'b1;
		cur.repne_terminate = 1'b1;
		cur.ld_gpr3 = 1'b1;
		cur.ex_c = random_bits(32);
		add_row("repne done");
		clear_row();
		cur.is_alu32 = 1'b1;
		cur.is_alu32_flags = 1'b1;
		cur.ex_a = random_bits(32);
		cur.ex_b = random_bits(32);
		cur.ld_gpr1 = 1'b1;
		cur.stall_cycles = 4'd3;
		add_row("stall 3");
		clear_row();
		cur.is_xchg = 1'b1;
		cur.ex_a = random_bits(32);
		cur.ex_b = random_bits(32);
		cur.ld_gpr2 = 1'b1;
		cur.stall_cycles = 4'd1;
		add_row("stall 1 xchg");
		clear_row();
		cur.aluk = aluk_xor;
		cur.is_alu32 = 1'b1;
		cur.ex_a = random_bits(32);
		cur.ex_b = random_bits(32);
		add_row("after stall");
	endtask

	task automatic apply_row(input stim_t s);
		ex_v = s.ex_v;
		ex_a = s.ex_a;
		ex_b = s.ex_b;
		ex_c = s.ex_c;
		aluk = s.aluk;
		datasize = s.datasize;
		is_alu32 = s.is_alu32;
		is_alu32_flags = s.is_alu32_flags;
		is_cmps_first = s.is_cmps_first;
		is_cmps_second = s.is_cmps_second;
		is_xchg = s.is_xchg;
		is_cmpxchg = s.is_cmpxchg;
		pass_a = s.pass_a;
		alu_to_b = s.alu_to_b;
		mux_sp_pop = s.mux_sp_pop;
		mux_cmps_pointer = s.mux_cmps_pointer;
		repne_steady = s.repne_steady;
		repne = s.repne;
		ld_gpr1 = s.ld_gpr1;
		ld_gpr2 = s.ld_gpr2;
		ld_gpr3 = s.ld_gpr3;
		dcache_write = s.dcache_write;
		saved_count = s.saved_count;
		flags_fwd = s.flags_fwd;
		repne_terminate = s.repne_terminate;
		wb_stall = (s.stall_cycles != 4'd0);
	endtask

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_flags(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t %s got %h expected %h (bits %h differ)",
				$time, name, got, exp, got ^ exp);
		end
	endtask

	task automatic check_outputs(input expect_t e, input string tag);
		check_bit({"wb_v", tag}, wb_v, e.v);
		check_bit({"wb_ld_gpr1", tag}, wb_ld_gpr1, e.ld_gpr1);
		check_bit({"wb_ld_gpr2", tag}, wb_ld_gpr2, e.ld_gpr2);
		check_bit({"wb_ld_gpr3", tag}, wb_ld_gpr3, e.ld_gpr3);
		check_bit({"wb_dcache_write", tag}, wb_dcache_write, e.dcache_write);
		check_word({"wb_result_a", tag}, wb_result_a, e.result_a);
		check_word({"wb_result_b", tag}, wb_result_b, e.result_b);
		check_word({"wb_result_c", tag}, wb_result_c, e.result_c);
		check_flags({"wb_flags", tag}, wb_flags, e.flags);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int      waited;
		int      row_errors;
		int      stall_left;
		int      rows_done;
		logic    loaded;
		expect_t prev;
		lfsr_state = 32'hd8a90837;
		model_saved = '0;
		checks = 0;
		errors = 0;
		rows_done = 0;
		timed_out = 1'b0;
		clear_row();
		apply_row(cur);
		build_table();

		waited = 0;
		while (rst_n !== 1'b1 && !timed_out) begin
			@(posedge CLK);
			#1;
			waited++;
			if (rst_n !== 1'b1 && waited > reset_timeout) begin
				$display("timeout: reset was never released");
				errors++;
				timed_out = 1'b1;
			end
		end

		// reset leaves everything at zero
		prev = '0;
		if (!timed_out) begin
			check_outputs(prev, " after reset");
		end

		for (int r = 0; r < stim_q.size() && !timed_out; r++) begin
			row_errors = errors;
			apply_row(stim_q[r]);
			stall_left = int'(stim_q[r].stall_cycles);
			loaded = 1'b0;
			waited = 0;
			while (!loaded && !timed_out) begin
				@(posedge CLK);
				loaded = !wb_stall;
				#1;
				waited++;
				if (!loaded) begin
					check_outputs(prev, " under stall");
					stall_left--;
					if (stall_left <= 0) begin
						wb_stall = 1'b0;
					end
					if (waited > stall_timeout) begin
						$display("timeout: row %0d still stalled after %0d cycles", r, waited);
						errors++;
						timed_out = 1'b1;
					end
				end
			end
			if (loaded) begin
				check_outputs(expect_q[r], "");
			end
			prev = expect_q[r];
			rows_done++;
			$display("row %0d %s: %s", r, name_q[r], (errors == row_errors) ? "ok" : "mismatch");
		end

		$display("rows %0d, checks %0d, errors %0d", rows_done, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/ex_tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module ex_tb_clock (
	output logic CLK,
	output logic rst_n
);

	localparam int reset_cycles = 5;

	initial CLK = 1'b0;

	// 8 ns period
	always #4 CLK = ~CLK;

	// released on an edge so the DUT sees exactly five reset edges
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) begin
			@(posedge CLK);
		end
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- execute/alu32.sv
`timescale 1ns/10ps
`default_nettype none

module alu32 import ex_pkg::*; (
	input  aluk_t     aluk,
	input  datasize_t datasize,
	input  word_t     a,
	input  word_t     b,
	input  logic      cf_in,
	input  logic      af_in,
	output word_t     result,
	output word_t     flags
);

	logic [32:0] sum;
	logic [32:0] diff;
	word_t       raw;
	word_t       size_mask;
	logic [4:0]  msb;
	logic        add_carry;
	logic        sub_borrow;
	logic        cf;
	logic        af;
	logic        of;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	// ----------------------------------------
	// size decode
	// ----------------------------------------
	// carry into bit n is a^b^r at bit n, which gives the carry out of a narrow op
	always_comb begin
		case (datasize)
			size_1: begin
				size_mask  = 32'h0000_00ff;
				msb        = 5'd7;
				add_carry  = a[8] ^ b[8] ^ sum[8];
				sub_borrow = a[8] ^ b[8] ^ diff[8];
			end
			size_2: begin
				size_mask  = 32'h0000_ffff;
				msb        = 5'd15;
				add_carry  = a[16] ^ b[16] ^ sum[16];
				sub_borrow = a[16] ^ b[16] ^ diff[16];
			end
			default: begin
				// size_8 runs as 32 bits here
				size_mask  = 32'hffff_ffff;
				msb        = 5'd31;
				add_carry  = sum[32];
				sub_borrow = diff[32];
			end
		endcase
	end

	// ----------------------------------------
	// operation
	// ----------------------------------------
	// sub also serves compare, the decoded enables drop the write
	always_comb begin
		raw = b;
		cf  = cf_in;
		af  = af_in;
		of  = 1'b0;
		case (aluk)
			aluk_add: begin
				raw = sum[31:0];
				cf  = add_carry;
				af  = a[4] ^ b[4] ^ sum[4];
				of  = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
			end
			aluk_sub: begin
				raw = diff[31:0];
				cf  = sub_borrow;
				af  = a[4] ^ b[4] ^ diff[4];
				of  = (a[msb] != b[msb]) && (diff[msb] != a[msb]);
			end
			aluk_and: raw = a & b;
			aluk_or:  raw = a | b;
			aluk_xor: raw = a ^ b;
			default:  raw = b;
		endcase
	end

	assign result = raw & size_mask;

	always_comb begin
		flags          = '0;
		flags[flag_cf] = cf;
		flags[flag_pf] = ~^result[7:0];
		flags[flag_af] = af;
		flags[flag_zf] = (result == '0);
		flags[flag_sf] = result[msb];
		flags[flag_of] = of;
	end

endmodule

`default_nettype wire

//--- execute/functional_unit.sv
`timescale 1ns/10ps
`default_nettype none

module functional_unit import ex_pkg::*; (
	input  aluk_t     aluk,
	input  datasize_t datasize,
	input  word_t     ex_a,
	input  word_t     ex_b,
	input  word_t     ex_c,
	input  word_t     b,
	input  word_t     count,
	input  word_t     flags_fwd,
	output word_t     alu_result,
	output word_t     alu_flags,
	output word_t     shift_result,
	output word_t     shift_flags,
	output word_t     count_minus_one,
	output word_t     sp_pop,
	output word_t     cmps_pointer
);

	logic [4:0]  shamt;
	logic [32:0] shl_ext;
	logic [32:0] shr_ext;
	logic        shift_cf;
	word_t       step;

	// ----------------------------------------
	// alu
	// ----------------------------------------
	alu32 u_alu32 (
		.aluk     (aluk),
		.datasize (datasize),
		.a        (ex_a),
		.b        (b),
		.cf_in    (flags_fwd[flag_cf]),
		.af_in    (flags_fwd[flag_af]),
		.result   (alu_result),
		.flags    (alu_flags)
	);

	// ----------------------------------------
	// shifter
	// ----------------------------------------
	assign shamt = ex_b[4:0];

	// one extra bit on each side catches the last bit shifted out
	assign shl_ext = {1'b0, ex_a} << shamt;
	assign shr_ext = {ex_a, 1'b0} >> shamt;

	always_comb begin
		if (aluk[0]) begin
			shift_result = shr_ext[32:1];
			shift_cf     = shr_ext[0];
		end else begin
			shift_result = shl_ext[31:0];
			shift_cf     = shl_ext[32];
		end
	end

	// zero count leaves the flags untouched
	always_comb begin
		shift_flags = flags_fwd;
		if (shamt != 5'd0) begin
			shift_flags[flag_cf] = shift_cf;
		end
	end

	// ----------------------------------------
	// count, stack and string pointers
	// ----------------------------------------
	assign count_minus_one = count - 32'd1;

	assign step   = step_bytes[datasize];
	assign sp_pop = ex_c + step;

	// DF set walks the string downward
	assign cmps_pointer = flags_fwd[flag_df] ? (ex_b - step) : (ex_b + step);

endmodule

`default_nettype wire

//--- execute/operand_select.sv
`timescale 1ns/10ps
`default_nettype none

module operand_select import ex_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,
	input  logic  is_cmps_first,
	input  logic  is_cmps_second,
	input  logic  repne_steady,
	input  word_t ex_a,
	input  word_t ex_b,
	input  word_t ex_c,
	input  word_t saved_count,
	output word_t b,
	output word_t count
);

	// first string-compare operand, held for the second micro-op
	word_t cmps_saved;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			cmps_saved <= '0;
		end else if (is_cmps_first) begin
			cmps_saved <= ex_a;
		end
	end

	// second micro-op compares against the saved value
	assign b = is_cmps_second ? cmps_saved : ex_b;

	// repne steady state keeps counting from the saved count
	assign count = repne_steady ? saved_count : ex_c;

endmodule

`default_nettype wire

//--- execute/result_select.sv
`timescale 1ns/10ps
`default_nettype none

module result_select import ex_pkg::*; (
	input  logic  is_alu32,
	input  logic  is_alu32_flags,
	input  logic  is_cmps_first,
	input  logic  is_cmps_second,
	input  logic  is_xchg,
	input  logic  is_cmpxchg,
	input  logic  pass_a,
	input  logic  alu_to_b,
	input  logic  mux_sp_pop,
	input  logic  mux_cmps_pointer,
	input  word_t ex_a,
	input  word_t ex_b,
	input  word_t ex_c,
	input  word_t alu_result,
	input  word_t alu_flags,
	input  word_t shift_result,
	input  word_t shift_flags,
	input  word_t count_minus_one,
	input  word_t sp_pop,
	input  word_t cmps_pointer,
	output word_t result_a,
	output word_t result_b,
	output word_t result_c,
	output word_t flags
);

	// ----------------------------------------
	// result a, highest priority first
	// ----------------------------------------
	always_comb begin
		if (is_alu32) begin
			result_a = alu_result;
		end else if (mux_cmps_pointer) begin
			result_a = cmps_pointer;
		end else if (is_cmps_first || is_xchg) begin
			result_a = ex_b;
		end else if (pass_a) begin
			result_a = ex_a;
		end else if (is_cmpxchg) begin
			result_a = ex_c;
		end else begin
			result_a = shift_result;
		end
	end

	// result b
	always_comb begin
		if (mux_cmps_pointer) begin
			result_b = cmps_pointer;
		end else if (alu_to_b) begin
			result_b = alu_result;
		end else if (is_cmpxchg || is_xchg) begin
			result_b = ex_a;
		end else begin
			result_b = ex_b;
		end
	end

	// result c carries the count for both compare micro-ops
	always_comb begin
		if (is_cmps_first || is_cmps_second) begin
			result_c = count_minus_one;
		end else if (mux_sp_pop) begin
			result_c = sp_pop;
		end else begin
			result_c = ex_c;
		end
	end

	assign flags = is_alu32_flags ? alu_flags : shift_flags;

endmodule

`default_nettype wire

//--- execute/write_enable_select.sv
`timescale 1ns/10ps
`default_nettype none

module write_enable_select (
	input  logic ex_v,
	input  logic is_cmpxchg,
	input  logic zf,
	input  logic ld_gpr1,
	input  logic ld_gpr2,
	input  logic ld_gpr3,
	input  logic dcache_write,
	output logic v_ld_gpr1,
	output logic v_ld_gpr2,
	output logic v_ld_gpr3,
	output logic v_dcache_write
);

	logic xchg_gpr1;
	logic xchg_gpr2;
	logic xchg_dcache;

	// cmpxchg: equal stores the source, unequal loads the accumulator
	always_comb begin
		xchg_gpr1   = ld_gpr1;
		xchg_gpr2   = ld_gpr2;
		xchg_dcache = dcache_write;
		if (is_cmpxchg) begin
			xchg_gpr1   = ld_gpr1 & zf;
			xchg_gpr2   = ld_gpr2 & ~zf;
			xchg_dcache = dcache_write & zf;
		end
	end

	// nothing writes from a bubble
	assign v_ld_gpr1      = ex_v & xchg_gpr1;
	assign v_ld_gpr2      = ex_v & xchg_gpr2;
	assign v_ld_gpr3      = ex_v & ld_gpr3;
	assign v_dcache_write = ex_v & xchg_dcache;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" && rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/10ps -f sources.f \
	--top-module ex_tb -Mdir obj_dir -o ex_tb_sim > build.log 2>&1 &&
./obj_dir/ex_tb_sim > sim.log 2>&1
grep -qx "=== PASS ===" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- source/ex_stage_top.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage_top import ex_pkg::*; (
	input  logic      CLK,
	input  logic      rst_n,
	input  logic      ex_v,
	input  word_t     ex_a,
	input  word_t     ex_b,
	input  word_t     ex_c,
	input  aluk_t     aluk,
	input  datasize_t datasize,
	input  logic      is_alu32,
	input  logic      is_alu32_flags,
	input  logic      is_cmps_first,
	input  logic      is_cmps_second,
	input  logic      is_xchg,
	input  logic      is_cmpxchg,
	input  logic      pass_a,
	input  logic      alu_to_b,
	input  logic      mux_sp_pop,
	input  logic      mux_cmps_pointer,
	input  logic      repne_steady,
	input  logic      repne,
	input  logic      ld_gpr1,
	input  logic      ld_gpr2,
	input  logic      ld_gpr3,
	input  logic      dcache_write,
	input  word_t     saved_count,
	input  word_t     flags_fwd,
	input  logic      wb_stall,
	input  logic      repne_terminate,
	output logic      wb_v,
	output logic      wb_ld_gpr1,
	output logic      wb_ld_gpr2,
	output logic      wb_ld_gpr3,
	output logic      wb_dcache_write,
	output word_t     wb_result_a,
	output word_t     wb_result_b,
	output word_t     wb_result_c,
	output word_t     wb_flags
);

	word_t    b;
	word_t    count;
	word_t    alu_result;
	word_t    alu_flags;
	word_t    shift_result;
	word_t    shift_flags;
	word_t    count_minus_one;
	word_t    sp_pop;
	word_t    cmps_pointer;
	logic     v_ld_gpr1;
	logic     v_ld_gpr2;
	logic     v_ld_gpr3;
	logic     v_dcache_write;
	logic     load;
	logic     wb_v_next;
	wb_data_t data_d;
	wb_data_t data_q;
	wb_ctrl_t ctrl_d;
	wb_ctrl_t ctrl_q;

	operand_select u_operand_select (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.is_cmps_first  (is_cmps_first),
		.is_cmps_second (is_cmps_second),
		.repne_steady   (repne_steady),
		.ex_a           (ex_a),
		.ex_b           (ex_b),
		.ex_c           (ex_c),
		.saved_count    (saved_count),
		.b              (b),
		.count          (count)
	);

	functional_unit u_functional_unit (
		.aluk            (aluk),
		.datasize        (datasize),
		.ex_a            (ex_a),
		.ex_b            (ex_b),
		.ex_c            (ex_c),
		.b               (b),
		.count           (count),
		.flags_fwd       (flags_fwd),
		.alu_result      (alu_result),
		.alu_flags       (alu_flags),
		.shift_result    (shift_result),
		.shift_flags     (shift_flags),
		.count_minus_one (count_minus_one),
		.sp_pop          (sp_pop),
		.cmps_pointer    (cmps_pointer)
	);

	write_enable_select u_write_enable_select (
		.ex_v           (ex_v),
		.is_cmpxchg     (is_cmpxchg),
		.zf             (alu_flags[flag_zf]),
		.ld_gpr1        (ld_gpr1),
		.ld_gpr2        (ld_gpr2),
		.ld_gpr3        (ld_gpr3),
		.dcache_write   (dcache_write),
		.v_ld_gpr1      (v_ld_gpr1),
		.v_ld_gpr2      (v_ld_gpr2),
		.v_ld_gpr3      (v_ld_gpr3),
		.v_dcache_write (v_dcache_write)
	);

	result_select u_result_select (
		.is_alu32         (is_alu32),
		.is_alu32_flags   (is_alu32_flags),
		.is_cmps_first    (is_cmps_first),
		.is_cmps_second   (is_cmps_second),
		.is_xchg          (is_xchg),
		.is_cmpxchg       (is_cmpxchg),
		.pass_a           (pass_a),
		.alu_to_b         (alu_to_b),
		.mux_sp_pop       (mux_sp_pop),
		.mux_cmps_pointer (mux_cmps_pointer),
		.ex_a             (ex_a),
		.ex_b             (ex_b),
		.ex_c             (ex_c),
		.alu_result       (alu_result),
		.alu_flags        (alu_flags),
		.shift_result     (shift_result),
		.shift_flags      (shift_flags),
		.count_minus_one  (count_minus_one),
		.sp_pop           (sp_pop),
		.cmps_pointer     (cmps_pointer),
		.result_a         (data_d.result_a),
		.result_b         (data_d.result_b),
		.result_c         (data_d.result_c),
		.flags            (data_d.flags)
	);

	// ----------------------------------------
	// stall and repne bubble
	// ----------------------------------------
	assign load = ~wb_stall;

	// a repeat iteration only reaches writeback once it terminates
	assign wb_v_next = repne ? (ex_v & repne_terminate) : ex_v;

	assign ctrl_d.v            = wb_v_next;
	assign ctrl_d.ld_gpr1      = v_ld_gpr1;
	assign ctrl_d.ld_gpr2      = v_ld_gpr2;
	assign ctrl_d.ld_gpr3      = v_ld_gpr3;
	assign ctrl_d.dcache_write = v_dcache_write;

	stage_latch #(.payload_t(wb_data_t)) u_data_latch (
		.CLK   (CLK),
		.rst_n (rst_n),
		.load  (load),
		.d     (data_d),
		.q     (data_q)
	);

	stage_latch #(.payload_t(wb_ctrl_t)) u_ctrl_latch (
		.CLK   (CLK),
		.rst_n (rst_n),
		.load  (load),
		.d     (ctrl_d),
		.q     (ctrl_q)
	);

	assign wb_v            = ctrl_q.v;
	assign wb_ld_gpr1      = ctrl_q.ld_gpr1;
	assign wb_ld_gpr2      = ctrl_q.ld_gpr2;
	assign wb_ld_gpr3      = ctrl_q.ld_gpr3;
	assign wb_dcache_write = ctrl_q.dcache_write;
	assign wb_result_a     = data_q.result_a;
	assign wb_result_b     = data_q.result_b;
	assign wb_result_c     = data_q.result_c;
	assign wb_flags        = data_q.flags;

endmodule

`default_nettype wire

//--- source/stage_latch.sv
`timescale 1ns/10ps
`default_nettype none

module stage_latch #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     CLK,
	input  logic     rst_n,
	input  logic     load,
	input  payload_t d,
	output payload_t q
);

	// holds while load is low
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			q <= '0;
		end else if (load) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- sources.f
common/ex_pkg.sv
execute/operand_select.sv
execute/alu32.sv
execute/functional_unit.sv
execute/write_enable_select.sv
execute/result_select.sv
source/stage_latch.sv
source/ex_stage_top.sv
dv/ex_checker.sv
dv/ex_tb_clock.sv
dv/ex_tb.sv
